/* project.f */
+incdir+verif
src/looper_isa_pkg.sv
src/looper_bus_pkg.sv
src/looper_mem.sv
src/looper_ctrl_regs.sv
src/looper_fetch.sv
src/looper_exec.sv
src/looper_tester.sv
verif/looper_tb.sv

/* Makefile */
# Verilator flow for the looper tester

VERILATOR ?= verilator
TOP       ?= looper_tb
RTL_TOP   ?= looper_tester
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation finished: PASS
VFLAGS    ?= --binary --timing --assert -j 0

SRCS     := $(shell grep -v '^+' $(FILELIST))
RTL_SRCS := $(filter src/%,$(SRCS))
HDRS     := $(wildcard verif/*.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || { echo "pass message not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verif/looper_model.svh */
`ifndef LOOPER_MODEL_SVH
`define LOOPER_MODEL_SVH

////////////////////////////////////////
// Reference model state
////////////////////////////////////////

// Program image with word i at base + i
looper_bus_pkg::word_t prog [$];
// Data region as the model expects it
looper_bus_pkg::word_t model_data [data_words];

// Register format word
function automatic looper_bus_pkg::word_t enc_alu(input logic [3:0] op, input logic [2:0] rd,
                                                  input logic [2:0] rs, input logic [31:0] imm);
   return {op, rd, rs, 22'd0, imm};
endfunction

// Loop format word
function automatic looper_bus_pkg::word_t enc_loop(input logic [15:0] count,
                                                   input looper_bus_pkg::addr_t target);
   return {looper_isa_pkg::op_loop, count, target, 30'd0};
endfunction

// One random straight-line instruction
function automatic looper_bus_pkg::word_t rand_op(input bit with_stores);
   int          kind;
   logic [3:0]  op;
   logic [2:0]  rd;
   logic [2:0]  rs;
   logic [31:0] imm;
   kind = with_stores ? $urandom_range(9, 0) : $urandom_range(6, 0);
   rd   = 3'($urandom_range(7, 0));
   rs   = 3'($urandom_range(7, 0));
   imm  = $urandom();
   if (kind == 0) begin
      // Plain NOP or a spare code
      if (imm[31]) begin
         op = looper_isa_pkg::op_nop;
      end else begin
         op = 4'($urandom_range(15, 6));
      end
   end else if (kind <= 3) begin
      op = looper_isa_pkg::op_loadi;
   end else if (kind <= 6) begin
      op = looper_isa_pkg::op_addi;
   end else begin
      op = looper_isa_pkg::op_store;
      // Data region 0x200 to 0x2FF with upper bits left random
      imm[13:8] = 6'h02;
   end
   return enc_alu(op, rd, rs, imm);
endfunction

// Random program ending in HALT with loops never nested
function automatic void gen_program(input looper_bus_pkg::addr_t base, input int n_blocks,
                                    input bit with_loops, input bit with_stores);
   int                    body_len;
   int                    n_loops;
   logic [15:0]           count;
   looper_bus_pkg::addr_t body_pc;
   prog.delete();
   n_loops = 0;
   for (int b = 0; b < n_blocks; b++) begin
      if (with_loops && ($urandom_range(1, 0) == 0)) begin
         body_pc  = base + looper_bus_pkg::addr_t'(prog.size());
         body_len = $urandom_range(4, 1);
         for (int i = 0; i < body_len; i++) begin
            prog.push_back(rand_op(with_stores));
         end
         // First loop of a program has count 0
         count = (n_loops == 0) ? 16'd0 : 16'($urandom_range(7, 0));
         n_loops++;
         prog.push_back(enc_loop(count, body_pc));
      end else begin
         prog.push_back(rand_op(with_stores));
      end
   end
   prog.push_back(enc_alu(looper_isa_pkg::op_halt, 3'd0, 3'd0, 32'd0));
endfunction

// ISA interpreter from cleared registers that returns the instructions run
function automatic int run_model(input looper_bus_pkg::addr_t base);
   looper_bus_pkg::word_t regs [8];
   looper_bus_pkg::word_t w;
   looper_bus_pkg::word_t imm_ext;
   logic [15:0]           lcnt;
   logic [15:0]           cur;
   logic                  lact;
   int                    pc;
   int                    next_pc;
   int                    steps;
   int                    a;
   for (int i = 0; i < 8; i++) begin
      regs[i] = '0;
   end
   lcnt  = '0;
   lact  = 1'b0;
   pc    = 0;
   steps = 0;
   while (pc >= 0 && pc < prog.size()) begin
      w       = prog[pc];
      imm_ext = {{32{w[31]}}, w[31:0]};
      next_pc = pc + 1;
      steps++;
      case (w[63:60])
         looper_isa_pkg::op_loadi: regs[w[59:57]] = imm_ext;
         looper_isa_pkg::op_addi:  regs[w[59:57]] = regs[w[56:54]] + imm_ext;
         looper_isa_pkg::op_store: begin
            a = int'(w[13:0]) - int'(data_base);
            if (a >= 0 && a < data_words) begin
               model_data[a] = regs[w[56:54]];
            end
         end
         looper_isa_pkg::op_loop: begin
            // Idle counter picks up the count field
            cur = lact ? lcnt : w[59:44];
            if (cur != 16'd0) begin
               lcnt    = cur - 16'd1;
               lact    = 1'b1;
               next_pc = int'(w[43:30]) - int'(base);
            end else begin
               lact = 1'b0;
            end
         end
         looper_isa_pkg::op_halt: return steps;
         default: begin
         end
      endcase
      pc = next_pc;
   end
   return steps;
endfunction

`endif

/* verif/looper_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module looper_tb;

   localparam int queue_depth   = 4;
   // Small enough to watch the LED toggle
   localparam int heartbeat_bit = 4;
   // Program slots and the data region
   localparam looper_bus_pkg::addr_t base_a    = 14'h000;
   localparam looper_bus_pkg::addr_t base_b    = 14'h100;
   localparam looper_bus_pkg::addr_t data_base = 14'h200;
   localparam int data_words  = 256;
   localparam int n_straight  = 4;
   localparam int n_loop      = 6;
   localparam int max_blocks  = 20;
   // Loop block is up to four body words plus the LOOP
   localparam int max_len     = max_blocks * 5 + 1;
   localparam int n_programs  = n_straight + n_loop + 2;
   // Every word runs at most eight times
   localparam int worst_instr = max_len * 8;
   localparam int load_cycles = n_programs * (2 * max_len + 3 * data_words + 16)
                                + 5 * data_words + 200;
   localparam int timeout_cycles = n_programs * worst_instr * 4 + load_cycles;

   logic                      clk_100MHz_buf;
   logic                      rst_n;
   looper_bus_pkg::mem_port_t host_port;
   looper_bus_pkg::word_t     host_rdata;
   looper_bus_pkg::addr_t     extern_pc;
   logic                      extern_pc_en;
   logic                      led_heartbeat;
   logic                      led_halted;
   int                        value_errors = 0;
   int                        other_errors = 0;

   looper_tester #(
      .queue_depth   (queue_depth),
      .heartbeat_bit (heartbeat_bit)
   ) u_looper_tester (
      .clk_100MHz_buf (clk_100MHz_buf),
      .rst_n          (rst_n),
      .host_port      (host_port),
      .host_rdata     (host_rdata),
      .extern_pc      (extern_pc),
      .extern_pc_en   (extern_pc_en),
      .led_heartbeat  (led_heartbeat),
      .led_halted     (led_halted)
   );

   `include "looper_model.svh"

   ////////////////////////////////////////
   // Compare and report
   ////////////////////////////////////////

   task automatic compare_word(input string name, input looper_bus_pkg::word_t got,
                               input looper_bus_pkg::word_t exp);
      if (got !== exp) begin
         value_errors++;
         $display("FAIL time=%0t %s got=%h expected=%h", $time, name, got, exp);
      end
   endtask

   task automatic compare_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         value_errors++;
         $display("FAIL time=%0t %s got=%b expected=%b", $time, name, got, exp);
      end
   endtask

   task automatic report_counts();
      $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
   endtask

   ////////////////////////////////////////
   // Host port driver
   ////////////////////////////////////////

   task automatic host_write(input looper_bus_pkg::addr_t a, input looper_bus_pkg::word_t d);
      @(posedge clk_100MHz_buf);
      host_port <= '{en: 1'b1, we: 1'b1, addr: a, wdata: d};
      @(posedge clk_100MHz_buf);
      host_port <= '0;
   endtask

   // Data is back one cycle after the request
   task automatic host_read(input looper_bus_pkg::addr_t a, output looper_bus_pkg::word_t d);
      @(posedge clk_100MHz_buf);
      host_port <= '{en: 1'b1, we: 1'b0, addr: a, wdata: '0};
      @(posedge clk_100MHz_buf);
      host_port <= '0;
      @(negedge clk_100MHz_buf);
      d = host_rdata;
   endtask

   task automatic load_program(input looper_bus_pkg::addr_t base);
      foreach (prog[i]) begin
         host_write(base + looper_bus_pkg::addr_t'(i), prog[i]);
      end
   endtask

   // Whole data region against the model
   task automatic readback_data();
      looper_bus_pkg::word_t got;
      looper_bus_pkg::addr_t a;
      for (int i = 0; i < data_words; i++) begin
         a = data_base + looper_bus_pkg::addr_t'(i);
         host_read(a, got);
         compare_word($sformatf("host_rdata[%h]", a), got, model_data[i]);
      end
   endtask

   // One cycle start pulse
   task automatic start_at(input looper_bus_pkg::addr_t pc);
      @(posedge clk_100MHz_buf);
      extern_pc    <= pc;
      extern_pc_en <= 1'b1;
      @(posedge clk_100MHz_buf);
      extern_pc_en <= 1'b0;
   endtask

   task automatic run_and_check(input looper_bus_pkg::addr_t base, input int steps);
      int cycles;
      start_at(base);
      @(negedge clk_100MHz_buf);
      compare_bit("led_halted", led_halted, 1'b0);
      cycles = 1;
      while (led_halted !== 1'b1) begin
         @(negedge clk_100MHz_buf);
         cycles++;
      end
      // At most one instruction per cycle
      if (cycles < steps) begin
         other_errors++;
         $display("Error at %0t: led_halted rose %0d cycles after start, too soon for %0d",
                  $time, cycles, steps);
         $display("instructions of the program to have run");
      end
      readback_data();
   endtask

   // LEDs from the first falling edge after reset release
   task automatic status_after_reset();
      logic exp_hb;
      exp_hb = 1'b0;
      @(negedge clk_100MHz_buf);
      for (int k = 0; k < 4 * (1 << heartbeat_bit); k++) begin
         // LED flips once per heartbeat period
         if (k != 0 && (k % (1 << heartbeat_bit)) == 0) begin
            exp_hb = ~exp_hb;
         end
         compare_bit("led_halted", led_halted, 1'b0);
         compare_bit("led_heartbeat", led_heartbeat, exp_hb);
         @(negedge clk_100MHz_buf);
      end
   endtask

   ////////////////////////////////////////
   // Clock and watchdog
   ////////////////////////////////////////

   initial begin
      clk_100MHz_buf = 1'b0;
      forever #5 clk_100MHz_buf = ~clk_100MHz_buf;
   end

   initial begin : watchdog
      repeat (timeout_cycles) @(posedge clk_100MHz_buf);
      other_errors++;
      $display("Timeout: the run did not end within %0d cycles, the core seems to hang",
               timeout_cycles);
      report_counts();
      $display("Simulation finished: FAIL");
      $finish;
   end

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////

   initial begin : main_seq
      looper_bus_pkg::word_t d;
      int                    steps;
      rst_n        = 1'b0;
      host_port    = '0;
      extern_pc    = '0;
      extern_pc_en = 1'b0;
      void'($urandom(32'h6e3698b6));
      repeat (10) @(posedge clk_100MHz_buf);
      rst_n <= 1'b1;
      status_after_reset();

      // Random data region through port B
      for (int i = 0; i < data_words; i++) begin
         d = {$urandom(), $urandom()};
         model_data[i] = d;
         host_write(data_base + looper_bus_pkg::addr_t'(i), d);
      end
      readback_data();

      // Straight-line programs
      repeat (n_straight) begin
         gen_program(base_a, $urandom_range(max_blocks, 4), 1'b0, 1'b1);
         load_program(base_a);
         steps = run_model(base_a);
         run_and_check(base_a, steps);
      end

      // Loops with stores against fetch
      repeat (n_loop) begin
         gen_program(base_a, $urandom_range(max_blocks, 4), 1'b1, 1'b1);
         load_program(base_a);
         steps = run_model(base_a);
         run_and_check(base_a, steps);
      end

      // Restart where the first program stores nothing and is cut short
      gen_program(base_b, 16, 1'b1, 1'b0);
      load_program(base_b);
      gen_program(base_a, 12, 1'b1, 1'b1);
      load_program(base_a);
      steps = run_model(base_a);
      start_at(base_b);
      @(negedge clk_100MHz_buf);
      compare_bit("led_halted", led_halted, 1'b0);
      repeat (4) @(posedge clk_100MHz_buf);
      run_and_check(base_a, steps);

      report_counts();
      if (value_errors == 0 && other_errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* src/looper_tester.sv */
`timescale 1ns/1ns
`default_nettype none

module looper_tester #(
   parameter int queue_depth   = 4,
   parameter int heartbeat_bit = 21
) (
   input  wire                            clk_100MHz_buf,
   input  wire                            rst_n,
   input  wire looper_bus_pkg::mem_port_t host_port,
   output wire looper_bus_pkg::word_t     host_rdata,
   input  wire looper_bus_pkg::addr_t     extern_pc,
   input  wire                            extern_pc_en,
   output wire                            led_heartbeat,
   output wire                            led_halted
);

   wire looper_bus_pkg::core_cfg_t  core_cfg;
   wire looper_bus_pkg::redirect_t  redirect;
   wire [$clog2(queue_depth+1)-1:0] credit_return;
   wire looper_bus_pkg::fetch_pkt_t fetch_pkt;
   wire looper_bus_pkg::mem_port_t  store;
   wire looper_bus_pkg::addr_t      rd_addr;
   wire looper_bus_pkg::word_t      rdata;
   wire                             rd_en;
   wire                             rd_accept;
   wire                             halt;

   ////////////////////////////////////////
   // Control and core
   ////////////////////////////////////////

   looper_ctrl_regs #(
      .heartbeat_bit (heartbeat_bit)
   ) u_ctrl_regs (
      .clk_100MHz_buf (clk_100MHz_buf),
      .rst_n          (rst_n),
      .extern_pc      (extern_pc),
      .extern_pc_en   (extern_pc_en),
      .halt           (halt),
      .core_cfg       (core_cfg),
      .led_heartbeat  (led_heartbeat),
      .led_halted     (led_halted)
   );

   looper_fetch #(
      .queue_depth (queue_depth)
   ) u_fetch (
      .clk_100MHz_buf (clk_100MHz_buf),
      .rst_n          (rst_n),
      .core_cfg       (core_cfg),
      .redirect       (redirect),
      .credit_return  (credit_return),
      .rd_en          (rd_en),
      .rd_addr        (rd_addr),
      .rd_accept      (rd_accept),
      .rdata          (rdata),
      .fetch_pkt      (fetch_pkt)
   );

   looper_exec #(
      .queue_depth (queue_depth)
   ) u_exec (
      .clk_100MHz_buf (clk_100MHz_buf),
      .rst_n          (rst_n),
      .core_cfg       (core_cfg),
      .fetch_pkt      (fetch_pkt),
      .credit_return  (credit_return),
      .redirect       (redirect),
      .store          (store),
      .halt           (halt)
   );

   // Port A shared by fetch and stores
   looper_mem u_mem (
      .clk_100MHz_buf (clk_100MHz_buf),
      .host_port      (host_port),
      .host_rdata     (host_rdata),
      .core_rd_en     (rd_en),
      .core_rd_addr   (rd_addr),
      .core_wr        (store),
      .rd_accept      (rd_accept),
      .core_rdata     (rdata)
   );

endmodule

`default_nettype wire

/* src/looper_exec.sv */
`timescale 1ns/1ns
`default_nettype none

module looper_exec #(
   parameter int queue_depth = 4
) (
   input  wire                             clk_100MHz_buf,
   input  wire                             rst_n,
   input  wire looper_bus_pkg::core_cfg_t  core_cfg,
   input  wire looper_bus_pkg::fetch_pkt_t fetch_pkt,
   output logic [$clog2(queue_depth+1)-1:0] credit_return,
   output looper_bus_pkg::redirect_t       redirect,
   output looper_bus_pkg::mem_port_t       store,
   output logic                            halt
);

   localparam int cnt_w = $clog2(queue_depth + 1);
   localparam int ptr_w = $clog2(queue_depth);

   // Instruction queue
   looper_bus_pkg::word_t   q_mem [queue_depth];
   logic [ptr_w-1:0]        wr_ptr;
   logic [ptr_w-1:0]        rd_ptr;
   logic [cnt_w-1:0]        q_count;
   logic                    exp_epoch;
   logic                    arrive_stale;
   logic                    push;
   logic                    restart;
   // Execute state
   looper_bus_pkg::word_t   regs [8];
   logic [15:0]             loop_cnt;
   logic                    loop_active;
   logic                    stopped;
   logic                    fire;
   looper_isa_pkg::instr_u  head;
   looper_isa_pkg::opcode_t op;
   looper_bus_pkg::word_t   imm_ext;
   logic [15:0]             loop_cur;
   logic                    do_jump;
   logic                    do_store;

   // Wrap for any depth
   function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
      return (p == ptr_w'(queue_depth - 1)) ? '0 : p + 1'b1;
   endfunction

   ////////////////////////////////////////
   // Decode of the queue head
   ////////////////////////////////////////

   assign head    = q_mem[rd_ptr];
   // Same nibble in both formats
   assign op      = head.alu.opcode;
   assign imm_ext = {{32{head.alu.imm[31]}}, head.alu.imm};
   // One instruction per cycle while running
   assign fire    = core_cfg.run && !core_cfg.flush && !stopped && (q_count != '0);

   // Inactive counter takes the count field
   assign loop_cur = loop_active ? loop_cnt : head.lp.count;
   assign do_jump  = fire && (op == looper_isa_pkg::op_loop) && (loop_cur != 16'd0);
   assign redirect = '{valid: do_jump, target: head.lp.target};

   // Granted in the same cycle
   assign do_store = fire && (op == looper_isa_pkg::op_store);
   assign store    = '{en: do_store, we: do_store, addr: head.alu.imm[13:0],
                       wdata: regs[head.alu.rs]};

   ////////////////////////////////////////
   // Queue and credits
   ////////////////////////////////////////

   assign restart      = core_cfg.flush || do_jump;
   // Old epoch or arriving during a restart
   assign arrive_stale = fetch_pkt.valid && (restart || (fetch_pkt.epoch != exp_epoch));
   assign push         = fetch_pkt.valid && !arrive_stale;
   // Whole queue back on restart
   assign credit_return = (restart ? q_count : cnt_w'(fire)) + cnt_w'(arrive_stale);

   always_ff @(posedge clk_100MHz_buf or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         q_count   <= '0;
         exp_epoch <= 1'b0;
      end else if (restart) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         q_count   <= '0;
         exp_epoch <= ~exp_epoch;
      end else begin
         if (push) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (fire) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         q_count <= q_count + cnt_w'(push) - cnt_w'(fire);
      end
   end

   always_ff @(posedge clk_100MHz_buf) begin
      if (push) begin
         q_mem[wr_ptr] <= fetch_pkt.instr;
      end
   end

   ////////////////////////////////////////
   // Registers, loop counter and halt
   ////////////////////////////////////////

   always_ff @(posedge clk_100MHz_buf or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
         loop_cnt    <= '0;
         loop_active <= 1'b0;
         stopped     <= 1'b0;
         halt        <= 1'b0;
      end else if (core_cfg.flush) begin
         // Fresh program state on start
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
         loop_cnt    <= '0;
         loop_active <= 1'b0;
         stopped     <= 1'b0;
         halt        <= 1'b0;
      end else begin
         halt <= 1'b0;
         if (fire) begin
            case (op)
               looper_isa_pkg::op_loadi: begin
                  regs[head.alu.rd] <= imm_ext;
               end
               looper_isa_pkg::op_addi: begin
                  regs[head.alu.rd] <= regs[head.alu.rs] + imm_ext;
               end
               looper_isa_pkg::op_loop: begin
                  // Falls through when the count runs out
                  loop_active <= do_jump;
                  loop_cnt    <= loop_cur - 16'd1;
               end
               looper_isa_pkg::op_halt: begin
                  halt    <= 1'b1;
                  stopped <= 1'b1;
               end
               default: begin
               end
            endcase
         end
      end
   end

   // Fetch credits must keep a slot free for every packet
   a_queue_room: assert property (@(posedge clk_100MHz_buf) disable iff (!rst_n)
      fetch_pkt.valid |-> (q_count < cnt_w'(queue_depth)))
      else $error("looper_exec: packet into a full queue");

endmodule

`default_nettype wire

/* src/looper_fetch.sv */
`timescale 1ns/1ns
`default_nettype none

module looper_fetch #(
   parameter int queue_depth = 4
) (
   input  wire                             clk_100MHz_buf,
   input  wire                             rst_n,
   input  wire looper_bus_pkg::core_cfg_t  core_cfg,
   input  wire looper_bus_pkg::redirect_t  redirect,
   input  wire [$clog2(queue_depth+1)-1:0] credit_return,
   output logic                            rd_en,
   output looper_bus_pkg::addr_t           rd_addr,
   input  wire                             rd_accept,
   input  wire looper_bus_pkg::word_t      rdata,
   output looper_bus_pkg::fetch_pkt_t      fetch_pkt
);

   localparam int cnt_w = $clog2(queue_depth + 1);

   looper_bus_pkg::addr_t pc;
   logic                  epoch;
   logic [cnt_w-1:0]      credits;
   logic                  restart;
   looper_bus_pkg::addr_t restart_pc;
   logic                  issue_epoch;
   logic                  accepted;
   // Tag stage beside the memory read
   logic                  tag_valid;
   logic                  tag_epoch;
   looper_bus_pkg::addr_t tag_pc;
   // Packet stage
   logic                  pkt_valid;
   logic                  pkt_epoch;
   looper_bus_pkg::addr_t pkt_pc;
   looper_bus_pkg::word_t pkt_instr;

   ////////////////////////////////////////
   // Read request
   ////////////////////////////////////////

   // Flush outranks a loop redirect
   assign restart     = core_cfg.flush || redirect.valid;
   assign restart_pc  = core_cfg.flush ? core_cfg.start_pc : redirect.target;
   // New epoch already on the restart read
   assign issue_epoch = restart ? ~epoch : epoch;
   // One credit per read
   assign rd_en       = core_cfg.run && (credits != '0);
   assign rd_addr     = restart ? restart_pc : pc;
   // A store can steal the port
   assign accepted    = rd_en && rd_accept;

   always_ff @(posedge clk_100MHz_buf or negedge rst_n) begin
      if (!rst_n) begin
         pc      <= '0;
         epoch   <= 1'b0;
         credits <= cnt_w'(queue_depth);
      end else begin
         epoch   <= issue_epoch;
         // Next sequential word after an accepted read
         pc      <= rd_addr + looper_bus_pkg::addr_t'(accepted);
         credits <= credits + credit_return - cnt_w'(accepted);
      end
   end

   ////////////////////////////////////////
   // Return path
   ////////////////////////////////////////

   // Valid two cycles after the accepted read
   always_ff @(posedge clk_100MHz_buf or negedge rst_n) begin
      if (!rst_n) begin
         tag_valid <= 1'b0;
         pkt_valid <= 1'b0;
      end else begin
         tag_valid <= accepted;
         pkt_valid <= tag_valid;
      end
   end

   // Tags and word
   always_ff @(posedge clk_100MHz_buf) begin
      tag_epoch <= issue_epoch;
      tag_pc    <= rd_addr;
      pkt_epoch <= tag_epoch;
      pkt_pc    <= tag_pc;
      pkt_instr <= rdata;
   end

   // Exec judges the epoch
   assign fetch_pkt = '{valid: pkt_valid, epoch: pkt_epoch, pc: pkt_pc, instr: pkt_instr};

   // Returns never exceed what was spent
   a_credit_range: assert property (@(posedge clk_100MHz_buf) disable iff (!rst_n)
      credits <= cnt_w'(queue_depth))
      else $error("looper_fetch: credit count %0d out of range", credits);

endmodule

`default_nettype wire

/* src/looper_ctrl_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module looper_ctrl_regs #(
   parameter int heartbeat_bit = 21
) (
   input  wire                        clk_100MHz_buf,
   input  wire                        rst_n,
   input  wire looper_bus_pkg::addr_t extern_pc,
   input  wire                        extern_pc_en,
   input  wire                        halt,
   output looper_bus_pkg::core_cfg_t  core_cfg,
   output logic                       led_heartbeat,
   output logic                       led_halted
);

   // Run flag, one cycle flush and start address
   looper_bus_pkg::core_cfg_t cfg_q;
   logic                      halted;
   // Free running heartbeat count
   logic [heartbeat_bit:0]    hb_cnt;

   ////////////////////////////////////////
   // Run state
   ////////////////////////////////////////

   always_ff @(posedge clk_100MHz_buf or negedge rst_n) begin
      if (!rst_n) begin
         cfg_q  <= '0;
         halted <= 1'b0;
      end else begin
         // Flush lasts one cycle
         cfg_q.flush <= 1'b0;
         // Start beats halt in the same cycle
         if (extern_pc_en) begin
            cfg_q.start_pc <= extern_pc;
            cfg_q.run      <= 1'b1;
            cfg_q.flush    <= 1'b1;
            halted         <= 1'b0;
         end else if (halt) begin
            cfg_q.run <= 1'b0;
            halted    <= 1'b1;
         end
      end
   end

   // Heartbeat
   always_ff @(posedge clk_100MHz_buf or negedge rst_n) begin
      if (!rst_n) begin
         hb_cnt <= '0;
      end else begin
         hb_cnt <= hb_cnt + 1'b1;
      end
   end

   assign core_cfg      = cfg_q;
   // Toggles every 2^heartbeat_bit cycles
   assign led_heartbeat = hb_cnt[heartbeat_bit];
   assign led_halted    = halted;

   // Exec only halts out of a running program
   a_halt_in_run: assert property (@(posedge clk_100MHz_buf) disable iff (!rst_n)
      halt |-> cfg_q.run)
      else $error("looper_ctrl_regs: halt while not running");

endmodule

`default_nettype wire

/* src/looper_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module looper_mem (
   input  wire                            clk_100MHz_buf,
   input  wire looper_bus_pkg::mem_port_t host_port,
   output looper_bus_pkg::word_t          host_rdata,
   input  wire                            core_rd_en,
   input  wire looper_bus_pkg::addr_t     core_rd_addr,
   input  wire looper_bus_pkg::mem_port_t core_wr,
   output logic                           rd_accept,
   output looper_bus_pkg::word_t          core_rdata
);

   localparam int depth = 2 ** looper_bus_pkg::addr_w;

   looper_bus_pkg::word_t mem_array [depth];
   logic                  wr_go;

   // Store wins port A
   assign wr_go     = core_wr.en && core_wr.we;
   // Fetch read only goes when no store
   assign rd_accept = core_rd_en && !wr_go;

   ////////////////////////////////////////
   // Both ports
   ////////////////////////////////////////

   always_ff @(posedge clk_100MHz_buf) begin
      // Port A core side
      if (wr_go) begin
         mem_array[core_wr.addr] <= core_wr.wdata;
      end else if (core_rd_en) begin
         core_rdata <= mem_array[core_rd_addr];
      end
      // Port B host side
      // Host stays off the array during a run
      if (host_port.en) begin
         if (host_port.we) begin
            mem_array[host_port.addr] <= host_port.wdata;
         end else begin
            host_rdata <= mem_array[host_port.addr];
         end
      end
   end

   // Exec register file must hold known data when it stores
   a_store_known: assert property (@(posedge clk_100MHz_buf)
      wr_go |-> !$isunknown(core_wr.wdata))
      else $error("looper_mem: unknown store data at %h", core_wr.addr);

endmodule

`default_nettype wire

/* src/looper_bus_pkg.sv */
`default_nettype none

package looper_bus_pkg;

   // 16384 words of program and data
   localparam int addr_w = 14;

   typedef logic [63:0]       word_t;
   typedef logic [addr_w-1:0] addr_t;

   ////////////////////////////////////////
   // Block to block transfers
   ////////////////////////////////////////

   // Host or core memory access
   typedef struct packed {
      logic  en;
      logic  we;
      addr_t addr;
      word_t wdata;
   } mem_port_t;

   // Tagged instruction from fetch to exec
   typedef struct packed {
      logic  valid;
      logic  epoch;
      addr_t pc;
      word_t instr;
   } fetch_pkt_t;

   // Taken loop back to fetch
   typedef struct packed {
      logic  valid;
      addr_t target;
   } redirect_t;

   // Run state from the control block
   typedef struct packed {
      logic  run;
      logic  flush;
      addr_t start_pc;
   } core_cfg_t;

endpackage

`default_nettype wire

/* src/looper_isa_pkg.sv */
`default_nettype none

package looper_isa_pkg;

   ////////////////////////////////////////
   // Opcodes
   ////////////////////////////////////////

   // Top nibble of every instruction word
   // Codes 6 to 15 run as NOP
   typedef enum logic [3:0] {
      op_nop   = 4'h0,
      op_loadi = 4'h1,
      op_addi  = 4'h2,
      op_store = 4'h3,
      op_loop  = 4'h4,
      op_halt  = 4'h5
   } opcode_t;

   ////////////////////////////////////////
   // Instruction formats
   ////////////////////////////////////////

   // Register format for LOADI, ADDI and STORE
   typedef struct packed {
      opcode_t     opcode;
      logic [2:0]  rd;
      logic [2:0]  rs;
      logic [21:0] unused;
      // Sign extended on use
      logic [31:0] imm;
   } alu_fmt_t;

   // Loop format
   typedef struct packed {
      opcode_t     opcode;
      logic [15:0] count;
      // Absolute word address of the loop body
      logic [13:0] target;
      logic [29:0] unused;
   } loop_fmt_t;

   // One word seen through either format
   typedef union packed {
      alu_fmt_t  alu;
      loop_fmt_t lp;
   } instr_u;

endpackage

`default_nettype wire
